// File: rtl/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

  // number of cpus behind the dispatcher
  localparam int CPU_QUANTITY = 4;
  // cycles to wait for a memory answer before aborting
  localparam int MEM_TIMEOUT_CYCLES = 50;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // cpu numbering and counting, count holds 0 .. CPU_QUANTITY
  typedef logic [1:0] cpu_idx_t;
  typedef logic [2:0] cpu_cnt_t;

  // memory wait counter, wide enough for MEM_TIMEOUT_CYCLES
  typedef logic [5:0] tmo_cnt_t;

  // messages sent by a polled cpu, other codes are ignored
  typedef enum logic [7:0] {
    MSG_NULL  = 8'h00,
    MSG_START = 8'h01,
    MSG_END   = 8'h02
  } cpu_msg_t;

  // controller FSM
  typedef enum logic [2:0] {
    CTL_CPU_LOOP,
    CTL_CPU_CMD,
    CTL_MEM_WORK,
    CTL_MEM_FINISH,
    CTL_EXT_BUS
  } ctl_state_t;

  // cpu select, active low means start offer
  typedef struct packed {
    logic     q;
    logic     active;
    cpu_idx_t index;
  } cpu_sel_t;

  // memory request, same layout on cpu and memory side
  typedef struct packed {
    logic  read_q;
    logic  write_q;
    addr_t addr;
    data_t data;
  } mem_req_t;

  // memory response
  typedef struct packed {
    logic  read_dn;
    logic  write_dn;
    logic  rw_halt;
    data_t data;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/cpu_scheduler.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_scheduler import dispatch_pkg::*; (
  input  wire      clk,
  input  wire      ext_rst_e,
  input  wire      poll_next,
  input  wire      msg_start,
  input  wire      msg_end,
  output cpu_sel_t cpu_sel
);

  // running and idle cpu counts, their sum stays CPU_QUANTITY
  cpu_cnt_t act_cnt;
  cpu_cnt_t inact_cnt;
  // round-robin pointer over running cpus
  cpu_idx_t rr_ptr;
  // set when the last poll was a start offer
  logic     last_offer;

  logic     do_offer;
  cpu_cnt_t ptr_inc;

  // pointer plus one, one bit wider so it compares with the count
  assign ptr_inc = cpu_cnt_t'(rr_ptr) + cpu_cnt_t'(1);

  // offer a start slot when some cpu idles
  // alternate with running cpus, unless none runs
  assign do_offer = (inact_cnt != '0) && (!last_offer || (act_cnt == '0));

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      act_cnt    <= '0;
      inact_cnt  <= cpu_cnt_t'(CPU_QUANTITY);
      rr_ptr     <= '0;
      last_offer <= 1'b0;
      cpu_sel    <= '0;
    end else begin
      // select strobe lasts one cycle
      cpu_sel.q <= 1'b0;

      if (poll_next) begin
        cpu_sel.q <= 1'b1;
        if (do_offer) begin
          cpu_sel.active <= 1'b0;
          cpu_sel.index  <= '0;
          last_offer     <= 1'b1;
        end else begin
          cpu_sel.active <= 1'b1;
          last_offer     <= 1'b0;
          // wrap after the last running cpu
          if (ptr_inc >= act_cnt) begin
            rr_ptr        <= '0;
            cpu_sel.index <= '0;
          end else begin
            rr_ptr        <= cpu_idx_t'(ptr_inc);
            cpu_sel.index <= cpu_idx_t'(ptr_inc);
          end
        end
      end

      // message bookkeeping, saturating at both ends
      if (msg_start && (inact_cnt != '0)) begin
        inact_cnt <= inact_cnt - cpu_cnt_t'(1);
        act_cnt   <= act_cnt + cpu_cnt_t'(1);
      end else if (msg_end && (act_cnt != '0)) begin
        act_cnt   <= act_cnt - cpu_cnt_t'(1);
        inact_cnt <= inact_cnt + cpu_cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/dispatch_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_ctl import dispatch_pkg::*; (
  input  wire      clk,
  input  wire      ext_rst_e,
  input  wire      cpu_e,
  input  cpu_msg_t cpu_msg_in,
  input  mem_req_t cpu_req,
  input  wire      mem_end,
  input  wire      ext_bus_q,
  output logic     poll_next,
  output logic     msg_start,
  output logic     msg_end,
  output logic     mem_go,
  output logic     ext_bus_allow
);

  ctl_state_t state;
  ctl_state_t state_nxt;

  // cpu holds its request as a level
  logic cpu_rq;

  assign cpu_rq = cpu_req.read_q | cpu_req.write_q;

  // next state and one-cycle strobes to scheduler and bridge
  always_comb begin
    state_nxt = state;
    poll_next = 1'b0;
    msg_start = 1'b0;
    msg_end   = 1'b0;
    mem_go    = 1'b0;

    case (state)
      CTL_CPU_LOOP: begin
        // external master wins over polling
        if (ext_bus_q) begin
          state_nxt = CTL_EXT_BUS;
        end else if (!cpu_e) begin
          poll_next = 1'b1;
          state_nxt = CTL_CPU_CMD;
        end
      end

      CTL_CPU_CMD: begin
        // memory request goes first, the bridge takes the payload now
        if (cpu_rq) begin
          mem_go    = 1'b1;
          state_nxt = CTL_MEM_WORK;
        end else if (cpu_e) begin
          // answer without request, decode the message
          case (cpu_msg_in)
            MSG_START: msg_start = 1'b1;
            MSG_END:   msg_end   = 1'b1;
            default: begin
              // null or unknown code, just poll on
            end
          endcase
          state_nxt = CTL_CPU_LOOP;
        end
      end

      CTL_MEM_WORK: begin
        // done, halt or timeout all end here
        if (mem_end) begin
          state_nxt = CTL_MEM_FINISH;
        end
      end

      CTL_MEM_FINISH: begin
        // one cycle gap so the cpu can drop its request
        state_nxt = CTL_CPU_LOOP;
      end

      CTL_EXT_BUS: begin
        if (!ext_bus_q) begin
          state_nxt = CTL_CPU_LOOP;
        end
      end

      default: begin
        state_nxt = CTL_CPU_LOOP;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state         <= CTL_CPU_LOOP;
      ext_bus_allow <= 1'b0;
    end else begin
      state <= state_nxt;
      // grant follows the master's request one cycle late
      if (state == CTL_EXT_BUS) begin
        ext_bus_allow <= ext_bus_q;
      end else begin
        ext_bus_allow <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module mem_bridge import dispatch_pkg::*; (
  input  wire      clk,
  input  wire      ext_rst_e,
  input  wire      mem_go,
  input  mem_req_t cpu_req,
  input  mem_rsp_t ext_mem_rsp,
  output mem_req_t ext_mem_req,
  output mem_rsp_t cpu_rsp,
  output logic     mem_end
);

  // request strobes toward memory
  logic     rd_q;
  logic     wr_q;
  // latched address and write data
  addr_t    addr_r;
  data_t    wdata_r;
  // access in flight and its direction
  logic     busy;
  logic     rd_op;
  tmo_cnt_t tmo_cnt;

  logic     rsp_rd_dn;
  logic     rsp_wr_dn;
  logic     rsp_halt;
  data_t    rsp_data;

  logic     mem_done;
  logic     tmo_hit;

  // only the done that matches the direction counts
  assign mem_done = rd_op ? ext_mem_rsp.read_dn : ext_mem_rsp.write_dn;
  // last waiting cycle before the abort
  assign tmo_hit  = (tmo_cnt == tmo_cnt_t'(MEM_TIMEOUT_CYCLES - 1));

  assign ext_mem_req = {rd_q, wr_q, addr_r, wdata_r};
  assign cpu_rsp     = {rsp_rd_dn, rsp_wr_dn, rsp_halt, rsp_data};

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      rd_q      <= 1'b0;
      wr_q      <= 1'b0;
      busy      <= 1'b0;
      rd_op     <= 1'b0;
      tmo_cnt   <= '0;
      rsp_rd_dn <= 1'b0;
      rsp_wr_dn <= 1'b0;
      rsp_halt  <= 1'b0;
      mem_end   <= 1'b0;
    end else begin
      // all strobes are single cycle
      rd_q      <= 1'b0;
      wr_q      <= 1'b0;
      rsp_rd_dn <= 1'b0;
      rsp_wr_dn <= 1'b0;
      rsp_halt  <= 1'b0;
      mem_end   <= 1'b0;

      if (mem_go && !busy) begin
        // read wins if the cpu raised both
        busy    <= 1'b1;
        rd_op   <= cpu_req.read_q;
        rd_q    <= cpu_req.read_q;
        wr_q    <= !cpu_req.read_q && cpu_req.write_q;
        tmo_cnt <= '0;
      end else if (busy) begin
        if (ext_mem_rsp.rw_halt) begin
          rsp_halt <= 1'b1;
          mem_end  <= 1'b1;
          busy     <= 1'b0;
        end else if (mem_done) begin
          rsp_rd_dn <= rd_op;
          rsp_wr_dn <= !rd_op;
          mem_end   <= 1'b1;
          busy      <= 1'b0;
        end else if (tmo_hit) begin
          // memory silent too long, abort without done
          rsp_halt <= 1'b1;
          mem_end  <= 1'b1;
          busy     <= 1'b0;
        end else begin
          tmo_cnt <= tmo_cnt + tmo_cnt_t'(1);
        end
      end
    end
  end

  // payload, held stable for the whole access
  always_ff @(posedge clk) begin
    if (mem_go && !busy) begin
      addr_r  <= cpu_req.addr;
      wdata_r <= cpu_req.data;
    end
    if (busy && rd_op && ext_mem_rsp.read_dn) begin
      rsp_data <= ext_mem_rsp.data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cpu_dispatcher.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_dispatcher import dispatch_pkg::*; (
  input  wire      clk,
  input  wire      ext_rst_e,
  // cpu side
  output cpu_sel_t cpu_sel,
  input  wire      cpu_e,
  input  cpu_msg_t cpu_msg_in,
  input  mem_req_t cpu_req,
  output mem_rsp_t cpu_rsp,
  // external memory
  output mem_req_t ext_mem_req,
  input  mem_rsp_t ext_mem_rsp,
  // external bus master
  input  wire      ext_bus_q,
  output logic     ext_bus_allow
);

  // controller to scheduler
  logic poll_next;
  logic msg_start;
  logic msg_end;
  // controller and bridge handshake
  logic mem_go;
  logic mem_end;

  // counts cpus and picks who is polled next
  cpu_scheduler cpu_scheduler_inst (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .poll_next (poll_next),
    .msg_start (msg_start),
    .msg_end   (msg_end),
    .cpu_sel   (cpu_sel)
  );

  // main FSM
  dispatch_ctl dispatch_ctl_inst (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_e         (cpu_e),
    .cpu_msg_in    (cpu_msg_in),
    .cpu_req       (cpu_req),
    .mem_end       (mem_end),
    .ext_bus_q     (ext_bus_q),
    .poll_next     (poll_next),
    .msg_start     (msg_start),
    .msg_end       (msg_end),
    .mem_go        (mem_go),
    .ext_bus_allow (ext_bus_allow)
  );

  // single outstanding memory access
  mem_bridge mem_bridge_inst (
    .clk         (clk),
    .ext_rst_e   (ext_rst_e),
    .mem_go      (mem_go),
    .cpu_req     (cpu_req),
    .ext_mem_rsp (ext_mem_rsp),
    .ext_mem_req (ext_mem_req),
    .cpu_rsp     (cpu_rsp),
    .mem_end     (mem_end)
  );

endmodule

`default_nettype wire

// File: bench/tb_cpu_dispatcher.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_dispatcher import dispatch_pkg::*; ();

  logic     clk;
  logic     ext_rst_e;
  logic     cpu_e;
  logic     ext_bus_q;
  logic     ext_bus_allow;
  cpu_sel_t cpu_sel;
  cpu_msg_t cpu_msg_in;
  mem_req_t cpu_req;
  mem_req_t ext_mem_req;
  mem_rsp_t cpu_rsp;
  mem_rsp_t ext_mem_rsp;

  // steps from the stimulus file
  logic [63:0] kind_q[$];
  data_t       op1_q[$];
  data_t       op2_q[$];
  data_t       exp_q[$];

  // memory model, written words, latest entry wins
  addr_t wr_addr_q[$];
  data_t wr_data_q[$];

  // reference scheduler state
  int ref_act = 0;
  int ref_inact = CPU_QUANTITY;
  int ref_ptr = 0;
  bit ref_offer = 1'b0;

  int sel_errs = 0;
  int rsp_errs = 0;
  int req_errs = 0;
  int flow_errs = 0;
  int cycle_cnt = 0;
  int cycle_limit = 1000000;

  cpu_dispatcher cpu_dispatcher_inst (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_sel       (cpu_sel),
    .cpu_e         (cpu_e),
    .cpu_msg_in    (cpu_msg_in),
    .cpu_req       (cpu_req),
    .cpu_rsp       (cpu_rsp),
    .ext_mem_req   (ext_mem_req),
    .ext_mem_rsp   (ext_mem_rsp),
    .ext_bus_q     (ext_bus_q),
    .ext_bus_allow (ext_bus_allow)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog, limit set once the stimulus is read
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("run stopped at the cycle limit of %0d", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic log_fail(input string what);
    $display("Fail %0d ns: %s", $time, what);
  endtask

  task automatic check_sel(input string what, input cpu_sel_t got, input cpu_sel_t exp);
    if (got !== exp) begin
      sel_errs++;
      log_fail($sformatf("%s: cpu_sel %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_rsp(input string what, input mem_rsp_t got, input mem_rsp_t exp,
                           input bit use_data);
    mem_rsp_t mask;
    // data only means something on a read done
    if (use_data) begin
      mask = '1;
    end else begin
      mask = {3'b111, 32'h0};
    end
    if (((got ^ exp) & mask) !== '0) begin
      rsp_errs++;
      log_fail($sformatf("%s: cpu_rsp %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_req(input string what, input mem_req_t got, input mem_req_t exp,
                           input bit use_payload);
    mem_req_t mask;
    if (use_payload) begin
      mask = '1;
    end else begin
      mask = {2'b11, 64'h0};
    end
    if (((got ^ exp) & mask) !== '0) begin
      req_errs++;
      log_fail($sformatf("%s: ext_mem_req %h, expected %h", what, got, exp));
    end
  endtask

  // offer when cpus idle, alternating with running ones
  task automatic predict_sel(output cpu_sel_t exp);
    exp.q = 1'b1;
    if (ref_inact > 0 && (!ref_offer || ref_act == 0)) begin
      exp.active = 1'b0;
      exp.index  = '0;
      ref_offer  = 1'b1;
    end else begin
      ref_ptr    = (ref_ptr + 1 >= ref_act) ? 0 : ref_ptr + 1;
      exp.active = 1'b1;
      exp.index  = cpu_idx_t'(ref_ptr);
      ref_offer  = 1'b0;
    end
  endtask

  // counts saturate at both ends
  task automatic apply_msg(input logic [7:0] code);
    if (code == MSG_START && ref_inact > 0) begin
      ref_act++;
      ref_inact--;
    end else if (code == MSG_END && ref_act > 0) begin
      ref_act--;
      ref_inact++;
    end
  endtask

  function automatic data_t mem_lookup(input addr_t a);
    data_t d;
    // unwritten words read back as the inverted address
    d = ~a;
    foreach (wr_addr_q[i]) begin
      if (wr_addr_q[i] == a) begin
        d = wr_data_q[i];
      end
    end
    return d;
  endfunction

  // wait for the select strobe and compare with the reference
  task automatic take_poll(output cpu_sel_t got);
    cpu_sel_t exp;
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cpu_sel.q && n < 8);
    got = cpu_sel;
    predict_sel(exp);
    if (!got.q) begin
      flow_errs++;
      $display("%0d ns: no cpu_sel.q came from the dispatcher", $time);
    end else begin
      check_sel("poll", got, exp);
    end
  endtask

  // cpu answers the poll with a message and no request
  task automatic answer_msg(input logic [7:0] code);
    @(posedge clk);
    cpu_e      <= 1'b1;
    cpu_msg_in <= cpu_msg_t'(code);
    @(posedge clk);
    cpu_e      <= 1'b0;
    cpu_msg_in <= MSG_NULL;
    apply_msg(code);
  endtask

  // cpu request held as a level, memory model answers after a random delay
  task automatic mem_access(input logic [63:0] kind, input addr_t a, input data_t wd,
                            input data_t exp);
    mem_req_t want;
    mem_rsp_t ans;
    mem_rsp_t rsp_exp;
    bit is_wr;
    bit seen;
    int n;
    int delay;
    is_wr = (kind == "write");
    want  = {!is_wr, is_wr, a, (is_wr ? wd : 32'h0)};
    @(posedge clk);
    cpu_req <= want;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 4) begin
      @(negedge clk);
      n++;
      seen = ext_mem_req.read_q | ext_mem_req.write_q;
    end
    if (!seen) begin
      flow_errs++;
      $display("%0d ns: no ext_mem_req strobe for the cpu request", $time);
    end
    check_req("memory request", ext_mem_req, want, 1'b1);
    if (is_wr) begin
      wr_addr_q.push_back(ext_mem_req.addr);
      wr_data_q.push_back(ext_mem_req.data);
    end
    if (kind == "silent") begin
      // memory never answers, count cycles to the abort
      n    = 0;
      seen = 1'b0;
      while (!seen && n < MEM_TIMEOUT_CYCLES + 8) begin
        @(negedge clk);
        n++;
        seen = cpu_rsp.read_dn | cpu_rsp.write_dn | cpu_rsp.rw_halt;
      end
      if (!seen) begin
        flow_errs++;
        $display("%0d ns: no abort came for the silent memory", $time);
      end else begin
        if (n != int'(exp)) begin
          rsp_errs++;
          log_fail($sformatf("abort after %0d cycles, expected %0d", n, exp));
        end
        check_rsp("timeout abort", cpu_rsp, {3'b001, 32'h0}, 1'b0);
      end
    end else begin
      delay = $urandom % 7;
      if (kind == "mhalt") begin
        ans     = {3'b001, 32'h0};
        rsp_exp = {3'b001, 32'h0};
      end else if (is_wr) begin
        ans     = {3'b010, 32'h0};
        rsp_exp = {3'b010, 32'h0};
      end else begin
        ans     = {3'b100, mem_lookup(a)};
        rsp_exp = {3'b100, exp};
      end
      repeat (delay) @(posedge clk);
      @(posedge clk);
      ext_mem_rsp <= ans;
      @(negedge clk);
      check_rsp("before memory answer", cpu_rsp, '0, 1'b0);
      @(posedge clk);
      ext_mem_rsp <= '0;
      // response one cycle after the memory pulse
      @(negedge clk);
      check_rsp("memory answer", cpu_rsp, rsp_exp, (kind == "read"));
    end
    @(posedge clk);
    cpu_req <= '0;
    @(negedge clk);
    check_rsp("after response", cpu_rsp, '0, 1'b0);
  endtask

  // master asks while the poll is pending, grant comes after the null answer
  task automatic grant_bus(input int hold);
    int n;
    @(posedge clk);
    ext_bus_q  <= 1'b1;
    cpu_e      <= 1'b1;
    cpu_msg_in <= MSG_NULL;
    @(posedge clk);
    cpu_e <= 1'b0;
    n = 0;
    while (!ext_bus_allow && n < 6) begin
      @(negedge clk);
      n++;
      if (cpu_sel.q) begin
        flow_errs++;
        $display("%0d ns: a cpu was polled while the bus was requested", $time);
      end
    end
    if (!ext_bus_allow) begin
      flow_errs++;
      $display("%0d ns: ext_bus_allow never rose", $time);
    end
    repeat (hold) begin
      @(negedge clk);
      if (ext_bus_allow !== 1'b1 || cpu_sel.q !== 1'b0) begin
        flow_errs++;
        log_fail("grant dropped or cpu polled during the grant");
      end
    end
    @(posedge clk);
    ext_bus_q <= 1'b0;
    @(negedge clk);
    if (ext_bus_allow !== 1'b1) begin
      flow_errs++;
      log_fail("ext_bus_allow fell together with ext_bus_q");
    end
    @(negedge clk);
    if (ext_bus_allow !== 1'b0) begin
      flow_errs++;
      log_fail("ext_bus_allow still high after the release");
    end
  endtask

  initial begin
    int fd;
    int cnt;
    int seed_val;
    logic [8*96-1:0] line_buf;
    logic [63:0] kind;
    data_t a;
    data_t b;
    data_t c;
    cpu_sel_t got;
    ext_rst_e   = 1'b1;
    cpu_e       = 1'b0;
    cpu_msg_in  = MSG_NULL;
    cpu_req     = '0;
    ext_mem_rsp = '0;
    ext_bus_q   = 1'b0;
    seed_val    = $urandom(32'h404e_3744);

    fd = $fopen("bench/dispatch_stimulus.txt", "r");
    if (fd == 0) begin
      flow_errs++;
      $display("cannot open bench/dispatch_stimulus.txt");
    end else begin
      line_buf = '0;
      while ($fgets(line_buf, fd) != 0) begin
        cnt = $sscanf(line_buf, "%s %h %h %h", kind, a, b, c);
        // blank and comment lines skipped
        if (cnt == 4 && kind != "#") begin
          kind_q.push_back(kind);
          op1_q.push_back(a);
          op2_q.push_back(b);
          exp_q.push_back(c);
        end
        line_buf = '0;
      end
      $fclose(fd);
    end
    cycle_limit = 16 + 80 * kind_q.size();

    repeat (16) @(posedge clk);
    ext_rst_e <= 1'b0;
    @(negedge clk);
    check_sel("after reset", cpu_sel, '0);
    check_rsp("after reset", cpu_rsp, '0, 1'b0);
    check_req("after reset", ext_mem_req, '0, 1'b0);
    if (ext_bus_allow !== 1'b0) begin
      flow_errs++;
      log_fail("ext_bus_allow high after reset");
    end

    foreach (kind_q[i]) begin
      // every step starts with a poll
      take_poll(got);
      case (kind_q[i])
        "msg": begin
          check_sel("poll against stimulus", got, cpu_sel_t'(exp_q[i][3:0]));
          answer_msg(op1_q[i][7:0]);
        end
        "read", "write", "mhalt", "silent": begin
          mem_access(kind_q[i], op1_q[i], op2_q[i], exp_q[i]);
        end
        "bus": begin
          grant_bus(int'(op1_q[i]));
        end
        default: begin
          flow_errs++;
          $display("unknown step kind in line %0d of the stimulus", i);
        end
      endcase
    end

    $display("errors: sel %0d, rsp %0d, req %0d, flow %0d",
             sel_errs, rsp_errs, req_errs, flow_errs);
    if (sel_errs + rsp_errs + req_errs + flow_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/dispatch_stimulus.txt
# kind op1 op2 expect, values in hex
# msg code - sel, read/mhalt/silent addr - data or abort cycles, write addr data -, bus hold
msg    01       00000000 8
msg    01       00000000 c
msg    00       00000000 8
read   00001000 00000000 ffffefff
write  00002000 cafe0001 00000000
read   00002000 00000000 cafe0001
msg    01       00000000 8
msg    05       00000000 d
mhalt  00003000 00000000 00000000
silent 00004000 00000000 32
msg    01       00000000 8
msg    00       00000000 f
msg    00       00000000 c
bus    6        00000000 00000000
msg    02       00000000 e
write  00005004 12345678 00000000
read   00005004 00000000 12345678
msg    02       00000000 8
msg    02       00000000 d
msg    02       00000000 8
msg    02       00000000 8
msg    00       00000000 8
bus    3        00000000 00000000
read   00000010 00000000 ffffffef

// File: src.f
rtl/dispatch_pkg.sv
rtl/cpu_scheduler.sv
rtl/dispatch_ctl.sv
rtl/mem_bridge.sv
rtl/cpu_dispatcher.sv
bench/tb_cpu_dispatcher.sv

// File: Bender.yml
package:
  name: cpu_dispatcher

sources:
  - rtl/dispatch_pkg.sv
  - rtl/cpu_scheduler.sv
  - rtl/dispatch_ctl.sv
  - rtl/mem_bridge.sv
  - rtl/cpu_dispatcher.sv
  - target: test
    files:
      - bench/tb_cpu_dispatcher.sv
